//--- hdl/softermax_fmt_pkg.sv
`default_nettype none

package softermax_fmt_pkg;

    // Scores are signed Q4.4
    localparam int score_w      = 8;
    localparam int score_frac_w = 4;

    // Signed integer row maximum, -8 to 8
    localparam int max_w = 5;

    // Unsigned exponent in Q1.7, range 0 to 1.0
    localparam int exp_w      = 8;
    localparam int exp_frac_w = 7;
    localparam int exp_one    = 1 << exp_frac_w;

    // Row sum keeps the exponent fraction
    localparam int sum_w = 12;

    // Slopes are Q2.8, intercepts Q2.12
    localparam int slope_w      = 10;
    localparam int slope_frac_w = 8;
    localparam int intercept_w  = 14;

    // Product d_frac * slope lines up with the intercept fraction
    localparam int prod_w      = score_frac_w + slope_w;
    localparam int lpw_frac_w  = score_frac_w + slope_frac_w;
    localparam int lpw_w       = 21;
    localparam int cast_drop_w = lpw_frac_w - exp_frac_w;

    // Secant of 2^f over [k/4, (k+1)/4], index k
    localparam logic [3:0][slope_w-1:0] seg_slope =
        {10'd326, 10'd274, 10'd230, 10'd194};
    localparam logic [3:0][intercept_w-1:0] seg_intercept =
        {14'd2978, 14'd3601, 14'd3949, 14'd4096};

endpackage

`default_nettype wire

//--- hdl/softermax_stream_pkg.sv
`default_nettype none

package softermax_stream_pkg;

    typedef struct packed {
        logic signed [softermax_fmt_pkg::score_w-1:0] score;
        logic                                         last;
    } score_beat_t;

    // Score minus row maximum, split into integer and fraction
    typedef struct packed {
        logic signed [softermax_fmt_pkg::max_w-1:0]   d_int;
        logic [softermax_fmt_pkg::score_frac_w-1:0]   d_frac;
        logic [softermax_fmt_pkg::max_w-1:0]          grow;
        logic signed [softermax_fmt_pkg::max_w-1:0]   row_max;
        logic                                         first;
        logic                                         last;
    } diff_beat_t;

    typedef struct packed {
        logic [softermax_fmt_pkg::exp_w-1:0] exp_val;
        logic                                last;
    } exp_beat_t;

    typedef struct packed {
        logic [softermax_fmt_pkg::sum_w-1:0]        sum_val;
        logic signed [softermax_fmt_pkg::max_w-1:0] row_max;
    } row_sum_t;

    // Row bookkeeping that rides along the pow2 pipeline
    typedef struct packed {
        logic [softermax_fmt_pkg::max_w-1:0]        grow;
        logic signed [softermax_fmt_pkg::max_w-1:0] row_max;
        logic                                       first;
        logic                                       last;
    } pow2_tag_t;

    typedef enum logic [1:0] {seg_q0, seg_q1, seg_q2, seg_q3} seg_e;

    typedef enum logic {acc_run, acc_hold} acc_state_e;

endpackage

`default_nettype wire

//--- hdl/skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter int DATA_W = 8
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [DATA_W-1:0] in_data,
    input  wire               in_valid,
    output logic              in_ready,
    output logic [DATA_W-1:0] out_data,
    output logic              out_valid,
    input  wire               out_ready
);

    logic [DATA_W-1:0] skid_data;
    logic              skid_valid;
    logic              in_fire;
    logic              out_free;

    assign in_fire  = in_valid && in_ready;
    assign out_free = out_ready || !out_valid;

    // Ready comes straight from a flop, never from out_ready
    assign in_ready = !skid_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            out_valid  <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    // Skid entry drains first, so order is kept
    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (in_fire && !out_free) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fixed_floor_cast.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_floor_cast (
    input  wire  [softermax_fmt_pkg::lpw_w-1:0] in_data,
    output logic [softermax_fmt_pkg::exp_w-1:0] out_data
);

    logic [softermax_fmt_pkg::lpw_w-softermax_fmt_pkg::cast_drop_w-1:0] floored;

    // Truncating unsigned bits is a floor
    assign floored = in_data[softermax_fmt_pkg::lpw_w-1:softermax_fmt_pkg::cast_drop_w];

    // Clamp anything above 1.0
    always_comb begin
        if (floored > softermax_fmt_pkg::exp_one) begin
            out_data = softermax_fmt_pkg::exp_w'(softermax_fmt_pkg::exp_one);
        end else begin
            out_data = floored[softermax_fmt_pkg::exp_w-1:0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/softermax_max_sub.sv
`timescale 1ns/1ps
`default_nettype none

module softermax_max_sub (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire softermax_stream_pkg::score_beat_t score_in,
    input  wire                               score_valid,
    output logic                              score_ready,
    output softermax_stream_pkg::diff_beat_t  diff_out,
    output logic                              diff_valid,
    input  wire                               diff_ready
);

    // Score extended to Q5.4 so that -16 fits
    logic signed [softermax_fmt_pkg::max_w+softermax_fmt_pkg::score_frac_w-1:0] score_ext;
    logic signed [softermax_fmt_pkg::max_w+softermax_fmt_pkg::score_frac_w-1:0] diff;
    logic signed [softermax_fmt_pkg::max_w-1:0] score_floor;
    logic signed [softermax_fmt_pkg::max_w-1:0] score_ceil;
    logic signed [softermax_fmt_pkg::max_w-1:0] cur_max;
    logic signed [softermax_fmt_pkg::max_w-1:0] new_max;
    logic                                       row_start;
    logic                                       score_fire;
    softermax_stream_pkg::diff_beat_t           diff_beat;

    assign score_ext   = $signed(score_in.score);
    assign score_floor = score_ext[softermax_fmt_pkg::max_w+softermax_fmt_pkg::score_frac_w-1
                                   -: softermax_fmt_pkg::max_w];

    // Round up when any fraction bit is set
    assign score_ceil = score_floor
                      + softermax_fmt_pkg::max_w'(score_in.score[softermax_fmt_pkg::score_frac_w-1:0] != '0);

    always_comb begin
        if (row_start || (score_ceil > cur_max)) begin
            new_max = score_ceil;
        end else begin
            new_max = cur_max;
        end
    end

    assign diff = score_ext - {new_max, {softermax_fmt_pkg::score_frac_w{1'b0}}};

    always_comb begin
        diff_beat.d_int   = diff[softermax_fmt_pkg::max_w+softermax_fmt_pkg::score_frac_w-1
                                 -: softermax_fmt_pkg::max_w];
        diff_beat.d_frac  = diff[softermax_fmt_pkg::score_frac_w-1:0];
        diff_beat.grow    = row_start ? '0 : new_max - cur_max;
        diff_beat.row_max = new_max;
        diff_beat.first   = row_start;
        diff_beat.last    = score_in.last;
    end

    assign score_fire = score_valid && score_ready;

    // Row state moves only on an accepted score
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_max   <= '0;
            row_start <= 1'b1;
        end else if (score_fire) begin
            cur_max   <= new_max;
            row_start <= score_in.last;
        end
    end

    skid_buffer #(
        .DATA_W($bits(softermax_stream_pkg::diff_beat_t))
    ) u_diff_skid (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (diff_beat),
        .in_valid (score_valid),
        .in_ready (score_ready),
        .out_data (diff_out),
        .out_valid(diff_valid),
        .out_ready(diff_ready)
    );

endmodule

`default_nettype wire

//--- hdl/softermax_lpw_pow2.sv
`timescale 1ns/1ps
`default_nettype none

module softermax_lpw_pow2 (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire softermax_stream_pkg::diff_beat_t diff_in,
    input  wire                                in_valid,
    output logic                               in_ready,
    output logic [softermax_fmt_pkg::exp_w-1:0] exp_out,
    output softermax_stream_pkg::pow2_tag_t    tag_out,
    output logic                               out_valid,
    input  wire                                out_ready
);

    typedef struct packed {
        logic [softermax_fmt_pkg::prod_w-1:0]       prod;
        softermax_stream_pkg::seg_e                 seg;
        logic signed [softermax_fmt_pkg::max_w-1:0] d_int;
        softermax_stream_pkg::pow2_tag_t            tag;
    } mul_beat_t;

    typedef struct packed {
        logic [softermax_fmt_pkg::lpw_w-1:0]        lpw;
        logic signed [softermax_fmt_pkg::max_w-1:0] d_int;
        softermax_stream_pkg::pow2_tag_t            tag;
    } add_beat_t;

    typedef struct packed {
        logic [softermax_fmt_pkg::lpw_w-1:0] lpw;
        softermax_stream_pkg::pow2_tag_t     tag;
    } shift_beat_t;

    typedef struct packed {
        logic [softermax_fmt_pkg::exp_w-1:0] exp_val;
        softermax_stream_pkg::pow2_tag_t     tag;
    } out_beat_t;

    mul_beat_t   mul_in, mul_q;
    add_beat_t   add_in, add_q;
    shift_beat_t shift_in, shift_q;
    out_beat_t   out_in, out_q;
    logic        mul_valid, mul_ready;
    logic        add_valid, add_ready;
    logic        shift_valid, shift_ready;
    logic [softermax_fmt_pkg::max_w-1:0] shamt;
    logic [softermax_fmt_pkg::exp_w-1:0] cast_out;

    // Stage 1: top two fraction bits pick the piece, then m * f
    always_comb begin
        mul_in.seg   = softermax_stream_pkg::seg_e'(
                           diff_in.d_frac[softermax_fmt_pkg::score_frac_w-1 -: 2]);
        mul_in.prod  = diff_in.d_frac * softermax_fmt_pkg::seg_slope[mul_in.seg];
        mul_in.d_int = diff_in.d_int;
        mul_in.tag   = '{grow: diff_in.grow, row_max: diff_in.row_max,
                         first: diff_in.first, last: diff_in.last};
    end

    skid_buffer #(.DATA_W($bits(mul_beat_t))) u_mul_skid (
        .clk(clk), .rst_n(rst_n),
        .in_data(mul_in), .in_valid(in_valid), .in_ready(in_ready),
        .out_data(mul_q), .out_valid(mul_valid), .out_ready(mul_ready)
    );

    // Stage 2: add the intercept, giving 2^f in Q2.12
    always_comb begin
        add_in.lpw   = mul_q.prod + softermax_fmt_pkg::seg_intercept[mul_q.seg];
        add_in.d_int = mul_q.d_int;
        add_in.tag   = mul_q.tag;
    end

    skid_buffer #(.DATA_W($bits(add_beat_t))) u_add_skid (
        .clk(clk), .rst_n(rst_n),
        .in_data(add_in), .in_valid(mul_valid), .in_ready(mul_ready),
        .out_data(add_q), .out_valid(add_valid), .out_ready(add_ready)
    );

    // Stage 3: d_int is never positive, so its negation is the shift
    assign shamt = -add_q.d_int;

    always_comb begin
        if (shamt >= softermax_fmt_pkg::exp_w) begin
            shift_in.lpw = '0;
        end else begin
            shift_in.lpw = add_q.lpw >> shamt;
        end
        shift_in.tag = add_q.tag;
    end

    skid_buffer #(.DATA_W($bits(shift_beat_t))) u_shift_skid (
        .clk(clk), .rst_n(rst_n),
        .in_data(shift_in), .in_valid(add_valid), .in_ready(add_ready),
        .out_data(shift_q), .out_valid(shift_valid), .out_ready(shift_ready)
    );

    fixed_floor_cast u_cast (
        .in_data (shift_q.lpw),
        .out_data(cast_out)
    );

    assign out_in.exp_val = cast_out;
    assign out_in.tag     = shift_q.tag;

    // Output register
    skid_buffer #(.DATA_W($bits(out_beat_t))) u_out_skid (
        .clk(clk), .rst_n(rst_n),
        .in_data(out_in), .in_valid(shift_valid), .in_ready(shift_ready),
        .out_data(out_q), .out_valid(out_valid), .out_ready(out_ready)
    );

    assign exp_out = out_q.exp_val;
    assign tag_out = out_q.tag;

endmodule

`default_nettype wire

//--- hdl/softermax_sum_acc.sv
`timescale 1ns/1ps
`default_nettype none

module softermax_sum_acc (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [softermax_fmt_pkg::exp_w-1:0] exp_in,
    input  wire softermax_stream_pkg::pow2_tag_t tag_in,
    input  wire                                 in_valid,
    output logic                                in_ready,
    output softermax_stream_pkg::exp_beat_t     exp_out,
    output logic                                exp_valid,
    input  wire                                 exp_ready,
    output softermax_stream_pkg::row_sum_t      sum_out,
    output logic                                sum_valid,
    input  wire                                 sum_ready
);

    softermax_stream_pkg::acc_state_e    state;
    softermax_stream_pkg::exp_beat_t     exp_beat;
    logic [softermax_fmt_pkg::sum_w-1:0] sum_q;
    logic [softermax_fmt_pkg::sum_w-1:0] sum_next;
    logic                                skid_ready;
    logic                                last_blocked;
    logic                                in_fire;
    logic                                sum_fire;

    // A last beat waits while the previous summary is still pending
    assign last_blocked = tag_in.last && sum_valid;
    assign in_ready     = skid_ready && (state == softermax_stream_pkg::acc_run)
                        && !last_blocked;
    assign in_fire      = in_valid && in_ready;
    assign sum_fire     = sum_valid && sum_ready;

    // Renormalise to the new maximum, a first beat starts from zero
    assign sum_next = (tag_in.first ? '0 : (sum_q >> tag_in.grow))
                    + softermax_fmt_pkg::sum_w'(exp_in);

    assign exp_beat.exp_val = exp_in;
    assign exp_beat.last    = tag_in.last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= softermax_stream_pkg::acc_run;
            sum_valid <= 1'b0;
        end else begin
            if (in_fire && tag_in.last) begin
                sum_valid <= 1'b1;
            end else if (sum_fire) begin
                sum_valid <= 1'b0;
            end
            if (sum_fire) begin
                state <= softermax_stream_pkg::acc_run;
            end else if (in_valid && last_blocked) begin
                state <= softermax_stream_pkg::acc_hold;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            sum_q <= sum_next;
            if (tag_in.last) begin
                sum_out.sum_val <= sum_next;
                sum_out.row_max <= tag_in.row_max;
            end
        end
    end

    skid_buffer #(
        .DATA_W($bits(softermax_stream_pkg::exp_beat_t))
    ) u_exp_skid (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (exp_beat),
        .in_valid (in_fire),
        .in_ready (skid_ready),
        .out_data (exp_out),
        .out_valid(exp_valid),
        .out_ready(exp_ready)
    );

endmodule

`default_nettype wire

//--- hdl/softermax_row_top.sv
`timescale 1ns/1ps
`default_nettype none

module softermax_row_top (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire softermax_stream_pkg::score_beat_t score_in,
    input  wire                                 score_valid,
    output logic                                score_ready,
    output softermax_stream_pkg::exp_beat_t     exp_out,
    output logic                                exp_valid,
    input  wire                                 exp_ready,
    output softermax_stream_pkg::row_sum_t      sum_out,
    output logic                                sum_valid,
    input  wire                                 sum_ready
);

    softermax_stream_pkg::diff_beat_t    diff;
    logic                                diff_valid;
    logic                                diff_ready;
    logic [softermax_fmt_pkg::exp_w-1:0] pow2_exp;
    softermax_stream_pkg::pow2_tag_t     pow2_tag;
    logic                                pow2_valid;
    logic                                pow2_ready;

    softermax_max_sub u_max_sub (
        .clk(clk), .rst_n(rst_n),
        .score_in(score_in), .score_valid(score_valid), .score_ready(score_ready),
        .diff_out(diff), .diff_valid(diff_valid), .diff_ready(diff_ready)
    );

    softermax_lpw_pow2 u_pow2 (
        .clk(clk), .rst_n(rst_n),
        .diff_in(diff), .in_valid(diff_valid), .in_ready(diff_ready),
        .exp_out(pow2_exp), .tag_out(pow2_tag),
        .out_valid(pow2_valid), .out_ready(pow2_ready)
    );

    softermax_sum_acc u_sum_acc (
        .clk(clk), .rst_n(rst_n),
        .exp_in(pow2_exp), .tag_in(pow2_tag), .in_valid(pow2_valid), .in_ready(pow2_ready),
        .exp_out(exp_out), .exp_valid(exp_valid), .exp_ready(exp_ready),
        .sum_out(sum_out), .sum_valid(sum_valid), .sum_ready(sum_ready)
    );

endmodule

`default_nettype wire

//--- dv/softermax_properties.sv
`timescale 1ns/1ps
`default_nettype none

module softermax_properties (
    input wire                                  clk,
    input wire                                  rst_n,
    input wire softermax_stream_pkg::exp_beat_t exp_out,
    input wire                                  exp_valid,
    input wire                                  exp_ready,
    input wire softermax_stream_pkg::row_sum_t  sum_out,
    input wire                                  sum_valid,
    input wire                                  sum_ready
);

    // A stalled beat keeps its valid and its data
    exp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid && !exp_ready |=> exp_valid && $stable(exp_out))
        else $error("exp_out changed or dropped while stalled");

    sum_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sum_valid && !sum_ready |=> sum_valid && $stable(sum_out))
        else $error("sum_out changed or dropped while stalled");

    // Outputs stay idle through reset
    reset_idle: assert property (@(posedge clk) !rst_n |=> !exp_valid && !sum_valid)
        else $error("valid output high during reset");

endmodule

bind softermax_row_top softermax_properties u_properties (
    .clk(clk), .rst_n(rst_n),
    .exp_out(exp_out), .exp_valid(exp_valid), .exp_ready(exp_ready),
    .sum_out(sum_out), .sum_valid(sum_valid), .sum_ready(sum_ready)
);

`default_nettype wire

//--- dv/softermax_tb.sv
`timescale 1ns/1ps
`default_nettype none

module softermax_tb;

    localparam int rand_rows = 40;
    // Upper bound on score beats over all tests
    localparam int total_beats = 1 + 48 + 18 + rand_rows * 8 + 20;
    localparam time latency_ns = 24;

    logic                              clk;
    logic                              rst_n;
    softermax_stream_pkg::score_beat_t score_in;
    logic                              score_valid;
    logic                              score_ready;
    softermax_stream_pkg::exp_beat_t   exp_out;
    logic                              exp_valid;
    logic                              exp_ready;
    softermax_stream_pkg::row_sum_t    sum_out;
    logic                              sum_valid;
    logic                              sum_ready;

    softermax_stream_pkg::exp_beat_t exp_q[$];
    softermax_stream_pkg::row_sum_t  sum_q[$];
    time                             accept_q[$];
    int                              row_buf[$];
    bit                              row_first;
    int                              row_max;
    int                              row_sum;
    bit                              check_latency;
    bit                              random_ready;
    bit                              saw_stall;
    int                              len;

    softermax_row_top DUT (
        .clk(clk), .rst_n(rst_n),
        .score_in(score_in), .score_valid(score_valid), .score_ready(score_ready),
        .exp_out(exp_out), .exp_valid(exp_valid), .exp_ready(exp_ready),
        .sum_out(sum_out), .sum_valid(sum_valid), .sum_ready(sum_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // Expected 2^d for one score and the row maximum and running sum after it
    function automatic int model_exp(input int score, input bit first,
                                     inout int cur_max, inout int sum);
        int ceil_v, new_max, grow;
        int d, d_int, d_frac, seg, lpw, e;
        ceil_v  = (score + 15) >>> 4;
        new_max = (first || ceil_v > cur_max) ? ceil_v : cur_max;
        grow    = first ? 0 : new_max - cur_max;
        d       = score - 16 * new_max;
        d_int   = d >>> 4;
        d_frac  = d & 15;
        seg     = d_frac >> 2;
        lpw     = d_frac * int'(softermax_fmt_pkg::seg_slope[seg])
                + int'(softermax_fmt_pkg::seg_intercept[seg]);
        lpw     = (-d_int >= 8) ? 0 : lpw >> (-d_int);
        e       = lpw >> 5;
        if (e > 128) begin
            e = 128;
        end
        sum     = first ? e : ((sum >> grow) + e) % 4096;
        cur_max = new_max;
        return e;
    endfunction

    task automatic check_exp(input softermax_stream_pkg::exp_beat_t expected);
        if (exp_out !== expected) begin
            stop_on_error($sformatf(
                "CHECK FAILED at %0t: exp_out expected exp=%0d last=%0b, got exp=%0d last=%0b",
                $time, expected.exp_val, expected.last, exp_out.exp_val, exp_out.last));
        end
    endtask

    task automatic check_sum(input softermax_stream_pkg::row_sum_t expected);
        if (sum_out !== expected) begin
            stop_on_error($sformatf(
                "CHECK FAILED at %0t: sum_out expected sum=%0d max=%0d, got sum=%0d max=%0d",
                $time, expected.sum_val, expected.row_max, sum_out.sum_val, sum_out.row_max));
        end
    endtask

    // Leaves score_valid high so that the next beat follows without a gap
    task automatic send_score(input logic signed [7:0] s, input bit last);
        softermax_stream_pkg::exp_beat_t exp_beat;
        softermax_stream_pkg::row_sum_t  sum_beat;
        @(negedge clk);
        score_in    = '{score: s, last: last};
        score_valid = 1'b1;
        @(posedge clk);
        while (!score_ready) begin
            @(posedge clk);
        end
        accept_q.push_back($time);
        exp_beat.exp_val = 8'(model_exp(int'(s), row_first, row_max, row_sum));
        exp_beat.last    = last;
        exp_q.push_back(exp_beat);
        if (last) begin
            sum_beat.sum_val = 12'(row_sum);
            sum_beat.row_max = 5'(row_max);
            sum_q.push_back(sum_beat);
        end
        row_first = last;
    endtask

    task automatic send_row();
        foreach (row_buf[i]) begin
            send_score(8'(row_buf[i]), i == row_buf.size() - 1);
        end
        @(negedge clk);
        score_valid = 1'b0;
        row_buf.delete();
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || sum_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (random_ready) begin
            exp_ready = ($urandom_range(3) != 0);
            sum_ready = ($urandom_range(1) != 0);
        end
    end

    // Scoreboard on both output streams
    always @(posedge clk) begin
        if (rst_n && exp_valid && exp_ready) begin
            if (exp_q.size() == 0) begin
                stop_on_error("exp_out delivered a beat that was never sent");
            end else begin
                if (check_latency && ($time - accept_q[0]) != latency_ns) begin
                    stop_on_error($sformatf("exp_out beat came %0t after acceptance, not %0t",
                                            $time - accept_q[0], latency_ns));
                end
                if (check_latency && exp_q[0].last && !sum_valid) begin
                    stop_on_error("sum_out was not valid with the last exp_out beat of the row");
                end
                check_exp(exp_q.pop_front());
                void'(accept_q.pop_front());
            end
        end
        if (rst_n && sum_valid && sum_ready) begin
            if (sum_q.size() == 0) begin
                stop_on_error("sum_out delivered a summary for no finished row");
            end else begin
                check_sum(sum_q.pop_front());
            end
        end
    end

    initial begin
        repeat (total_beats * 20 + 200) @(posedge clk);
        stop_on_error("Timeout: the DUT stopped delivering beats");
    end

    initial begin
        void'($urandom(4472));
        rst_n         = 1'b0;
        score_in      = '0;
        score_valid   = 1'b0;
        exp_ready     = 1'b1;
        sum_ready     = 1'b1;
        row_first     = 1'b1;
        row_max       = 0;
        row_sum       = 0;
        check_latency = 1'b0;
        random_ready  = 1'b0;
        saw_stall     = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Single score of zero with exact latency
        check_latency = 1'b1;
        row_buf.push_back(0);
        send_row();
        wait_drained();
        check_latency = 1'b0;

        // Ascending through every piece and fraction
        for (int i = -24; i < 24; i++) begin
            row_buf.push_back(i);
        end
        send_row();
        wait_drained();

        // Descending from the top of the range to -8.0
        for (int i = 0; i < 18; i++) begin
            row_buf.push_back(127 - 15 * i);
        end
        send_row();
        wait_drained();

        // Random rows under random back-pressure
        random_ready = 1'b1;
        repeat (rand_rows) begin
            len = $urandom_range(8, 1);
            repeat (len) row_buf.push_back(int'($urandom_range(255)) - 128);
            send_row();
        end
        wait_drained();
        random_ready = 1'b0;
        @(negedge clk);
        exp_ready = 1'b1;

        // Single-score rows while sum_out is stalled
        sum_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 20; i++) begin
                    send_score(8'($urandom_range(255)), 1'b1);
                end
                @(negedge clk);
                score_valid = 1'b0;
            end
            begin
                for (int n = 0; n < 100 && !saw_stall; n++) begin
                    @(posedge clk);
                    saw_stall = score_valid && !score_ready;
                end
                if (!saw_stall) begin
                    stop_on_error("score_ready never fell while sum_out was stalled");
                end
                @(negedge clk);
                sum_ready = 1'b1;
            end
        join
        wait_drained();

        repeat (10) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/softermax_fmt_pkg.sv
hdl/softermax_stream_pkg.sv
hdl/skid_buffer.sv
hdl/fixed_floor_cast.sv
hdl/softermax_max_sub.sv
hdl/softermax_lpw_pow2.sv
hdl/softermax_sum_acc.sv
hdl/softermax_row_top.sv
dv/softermax_properties.sv
dv/softermax_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the softermax testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module softermax_tb -f list.f -o softermax_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/softermax_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
